/* design/bgpu_pkg.sv */
/*
 * Sizes and types of the integer path. RESULT_DEPTH must be a power of two.
 * Subtype codes outside iu_subtype_e give all-ones data and are not flagged.
 */
package bgpu_pkg;

    // ############################
    // Sizes
    // ############################

    localparam int unsigned NUM_WARPS    = 4;
    localparam int unsigned WARP_WIDTH   = 4;
    localparam int unsigned REG_WIDTH    = 32;
    localparam int unsigned NUM_REGS     = 16;
    localparam int unsigned NUM_TAGS     = 8;
    localparam int unsigned RESULT_DEPTH = 4;

    // Derived widths
    localparam int unsigned WID_WIDTH     = $clog2(NUM_WARPS);
    localparam int unsigned TAG_WIDTH     = $clog2(NUM_TAGS);
    localparam int unsigned REG_IDX_WIDTH = $clog2(NUM_REGS);

    // Result buffer pointer and occupancy widths
    localparam int unsigned RB_PTR_WIDTH = $clog2(RESULT_DEPTH);
    localparam int unsigned RB_CNT_WIDTH = $clog2(RESULT_DEPTH + 1);

    // ############################
    // Vector types
    // ############################

    typedef logic [REG_WIDTH-1:0]            reg_data_t;
    // Thread i sits at bits [i*REG_WIDTH +: REG_WIDTH]
    typedef logic [WARP_WIDTH*REG_WIDTH-1:0] warp_data_t;
    typedef logic [REG_IDX_WIDTH-1:0]        reg_idx_t;
    typedef logic [WID_WIDTH-1:0]            wid_t;
    typedef logic [TAG_WIDTH-1:0]            tag_t;
    // Tag in the upper bits, warp ID in the lower bits
    typedef logic [TAG_WIDTH+WID_WIDTH-1:0]  iid_t;

    // Integer unit operations
    typedef enum logic [3:0] {
        IU_TID  = 4'd0,
        IU_WID  = 4'd1,
        IU_ADD  = 4'd2,
        IU_ADDI = 4'd3,
        IU_SUB  = 4'd4,
        IU_SUBI = 4'd5,
        IU_LDI  = 4'd6,
        IU_OR   = 4'd7,
        IU_AND  = 4'd8,
        IU_XOR  = 4'd9,
        IU_SLL  = 4'd10,
        IU_SLLI = 4'd11
    } iu_subtype_e;

    // ############################
    // Stream payloads
    // ############################

    // Instruction from the issue port
    typedef struct packed {
        wid_t        wid;
        iu_subtype_e subtype;
        reg_idx_t    dst;
        reg_idx_t    src0;
        reg_idx_t    src1;
        reg_data_t   imm;
    } issue_t;

    // Collector to integer unit
    typedef struct packed {
        iid_t                  iid;
        iu_subtype_e           subtype;
        reg_idx_t              dst;
        warp_data_t [1:0]      operands;
    } iu_req_t;

    // Integer unit result, also the buffer entry
    typedef struct packed {
        iid_t       iid;
        reg_idx_t   dst;
        warp_data_t data;
    } iu_result_t;

    // Writeback port
    typedef struct packed {
        wid_t       wid;
        reg_idx_t   dst;
        warp_data_t data;
    } wb_t;

endpackage

/* design/warp_register_file.sv */
/*
 * Registered reads, held while rd_en_i is low. A write to the register being
 * read in the same cycle is forwarded, so reads see the new value.
 */
`timescale 1ns/1ps

module warp_register_file import bgpu_pkg::*; (
    input  logic       clk_i,
    input  logic       rst_i,
    input  logic       rd_en_i,
    input  wid_t       rd_wid_i,
    input  reg_idx_t   rd_idx0_i,
    input  reg_idx_t   rd_idx1_i,
    output warp_data_t rd_data0_o,
    output warp_data_t rd_data1_o,
    input  logic       wr_en_i,
    input  wid_t       wr_wid_i,
    input  reg_idx_t   wr_idx_i,
    input  warp_data_t wr_data_i
);

    // One warp-wide register per warp and index
    warp_data_t regs_q [NUM_WARPS][NUM_REGS];

    logic hit0;
    logic hit1;

    // Write port targets a register being read this cycle
    assign hit0 = wr_en_i && (wr_wid_i == rd_wid_i) && (wr_idx_i == rd_idx0_i);
    assign hit1 = wr_en_i && (wr_wid_i == rd_wid_i) && (wr_idx_i == rd_idx1_i);

    // Storage, zero after reset
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            for (int w = 0; w < NUM_WARPS; w++) begin
                for (int r = 0; r < NUM_REGS; r++) begin
                    regs_q[w][r] <= '0;
                end
            end
        end else if (wr_en_i) begin
            regs_q[wr_wid_i][wr_idx_i] <= wr_data_i;
        end
    end

    // Read ports with write forwarding
    always_ff @(posedge clk_i) begin
        if (rd_en_i) begin
            rd_data0_o <= hit0 ? wr_data_i : regs_q[rd_wid_i][rd_idx0_i];
            rd_data1_o <= hit1 ? wr_data_i : regs_q[rd_wid_i][rd_idx1_i];
        end
    end

endmodule

/* design/operand_collector.sv */
/*
 * Holds one request. issue_ready_o depends on issue_i, since hazards are
 * checked against the offered instruction. Tags roll over every NUM_TAGS.
 */
`timescale 1ns/1ps

module operand_collector import bgpu_pkg::*; (
    input  logic       clk_i,
    input  logic       rst_i,

    // Issue port
    input  logic       issue_valid_i,
    output logic       issue_ready_o,
    input  issue_t     issue_i,

    // Register file read port
    output logic       rd_en_o,
    output wid_t       rd_wid_o,
    output reg_idx_t   rd_idx0_o,
    output reg_idx_t   rd_idx1_o,
    input  warp_data_t rd_data0_i,
    input  warp_data_t rd_data1_i,

    // Scoreboard release from writeback
    input  logic       clr_valid_i,
    input  wid_t       clr_wid_i,
    input  reg_idx_t   clr_dst_i,

    // Request to the integer unit
    output logic       req_valid_o,
    input  logic       req_ready_i,
    output iu_req_t    req_o
);

    // ############################
    // Scoreboard and hazards
    // ############################

    logic [NUM_WARPS-1:0][NUM_REGS-1:0] pending_q;
    logic [NUM_WARPS-1:0][NUM_REGS-1:0] pending_clr;
    logic [NUM_WARPS-1:0][NUM_REGS-1:0] pending_d;

    logic use_src0;
    logic use_src1;
    logic hazard;
    logic stage_free;
    logic accept;

    // Which sources the offered instruction actually reads
    always_comb begin
        use_src0 = 1'b1;
        use_src1 = 1'b1;
        case (issue_i.subtype)
            IU_TID, IU_WID, IU_LDI: begin
                use_src0 = 1'b0;
                use_src1 = 1'b0;
            end
            // Operand 0 comes from the immediate
            IU_ADDI, IU_SUBI, IU_SLLI: use_src0 = 1'b0;
            default: use_src0 = 1'b1;
        endcase
    end

    // Writeback release lands before the hazard check
    always_comb begin
        pending_clr = pending_q;
        if (clr_valid_i) begin
            pending_clr[clr_wid_i][clr_dst_i] = 1'b0;
        end
    end

    assign hazard = (use_src0 && pending_clr[issue_i.wid][issue_i.src0])
                 || (use_src1 && pending_clr[issue_i.wid][issue_i.src1])
                 || pending_clr[issue_i.wid][issue_i.dst];

    // Output stage empty or handing off this cycle
    assign stage_free    = !req_valid_o || req_ready_i;
    assign issue_ready_o = stage_free && !hazard;
    assign accept        = issue_valid_i && issue_ready_o;

    // Mark destination pending on acceptance
    always_comb begin
        pending_d = pending_clr;
        if (accept) begin
            pending_d[issue_i.wid][issue_i.dst] = 1'b1;
        end
    end

    // ############################
    // Request stage
    // ############################

    tag_t        tag_q;
    iid_t        iid_q;
    iu_subtype_e subtype_q;
    reg_idx_t    dst_q;
    reg_data_t   imm_q;
    logic        imm_op;

    // Register read runs alongside the capture below
    assign rd_en_o   = accept;
    assign rd_wid_o  = issue_i.wid;
    assign rd_idx0_o = issue_i.src0;
    assign rd_idx1_o = issue_i.src1;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            pending_q   <= '0;
            tag_q       <= '0;
            req_valid_o <= 1'b0;
        end else begin
            pending_q <= pending_d;
            if (accept) begin
                tag_q       <= tag_q + 1'b1;
                req_valid_o <= 1'b1;
            end else if (req_ready_i) begin
                req_valid_o <= 1'b0;
            end
        end
    end

    // Instruction fields, operands arrive from the register file
    always_ff @(posedge clk_i) begin
        if (accept) begin
            iid_q     <= {tag_q, issue_i.wid};
            subtype_q <= issue_i.subtype;
            dst_q     <= issue_i.dst;
            imm_q     <= issue_i.imm;
        end
    end

    assign imm_op = subtype_q inside {IU_ADDI, IU_SUBI, IU_SLLI, IU_LDI};

    // Immediate broadcast to all threads, LDI ORs with zero
    always_comb begin
        req_o.iid         = iid_q;
        req_o.subtype     = subtype_q;
        req_o.dst         = dst_q;
        req_o.operands[0] = imm_op ? {WARP_WIDTH{imm_q}} : rd_data0_i;
        req_o.operands[1] = (subtype_q == IU_LDI) ? '0 : rd_data1_i;
    end

endmodule

/* design/integer_unit.sv */
/*
 * Binary operations compute operand 1 op operand 0, modulo 2**REG_WIDTH.
 * Shift amounts of REG_WIDTH or more give zero. Unknown subtypes give all ones.
 */
`timescale 1ns/1ps

module integer_unit import bgpu_pkg::*; (
    input  logic       clk_i,
    input  logic       rst_i,

    // From the operand collector
    input  logic       req_valid_i,
    output logic       req_ready_o,
    input  iu_req_t    req_i,

    // To the result buffer
    output logic       res_valid_o,
    input  logic       res_ready_i,
    output iu_result_t res_o
);

    // ############################
    // Per-thread ALU
    // ############################

    warp_data_t result;

    always_comb begin
        reg_data_t a;
        reg_data_t b;
        reg_data_t r;
        wid_t      wid;

        result = '0;
        wid    = req_i.iid[WID_WIDTH-1:0];
        for (int i = 0; i < WARP_WIDTH; i++) begin
            // Operand 0 and operand 1 of thread i
            a = req_i.operands[0][i*REG_WIDTH +: REG_WIDTH];
            b = req_i.operands[1][i*REG_WIDTH +: REG_WIDTH];
            case (req_i.subtype)
                IU_TID:           r = reg_data_t'(i);
                IU_WID:           r = reg_data_t'(wid);
                IU_ADD, IU_ADDI:  r = b + a;
                IU_SUB, IU_SUBI:  r = b - a;
                // LDI arrives with operand 1 zeroed
                IU_LDI, IU_OR:    r = b | a;
                IU_AND:           r = b & a;
                IU_XOR:           r = b ^ a;
                IU_SLL, IU_SLLI:  r = b << a;
                default:          r = '1;
            endcase
            result[i*REG_WIDTH +: REG_WIDTH] = r;
        end
    end

    // ############################
    // Output register
    // ############################

    // Takes new data when empty or being emptied
    assign req_ready_o = !res_valid_o || res_ready_i;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            res_valid_o <= 1'b0;
        end else if (req_ready_o) begin
            res_valid_o <= req_valid_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (req_valid_i && req_ready_o) begin
            res_o.iid  <= req_i.iid;
            res_o.dst  <= req_i.dst;
            res_o.data <= result;
        end
    end

endmodule

/* design/result_buffer.sv */
/*
 * Circular FIFO, RESULT_DEPTH a power of two. No write-through when empty,
 * a written entry shows at the output one cycle later. Ready low when full.
 */
`timescale 1ns/1ps

module result_buffer import bgpu_pkg::*; (
    input  logic       clk_i,
    input  logic       rst_i,

    // From the integer unit
    input  logic       in_valid_i,
    output logic       in_ready_o,
    input  iu_result_t in_i,

    // To the result collector
    output logic       out_valid_o,
    input  logic       out_ready_i,
    output iu_result_t out_o
);

    iu_result_t mem_q [RESULT_DEPTH];

    logic [RB_PTR_WIDTH-1:0] wr_ptr_q;
    logic [RB_PTR_WIDTH-1:0] rd_ptr_q;
    logic [RB_CNT_WIDTH-1:0] count_q;

    logic push;
    logic pop;

    assign in_ready_o  = (count_q != RB_CNT_WIDTH'(RESULT_DEPTH));
    assign out_valid_o = (count_q != '0);
    assign out_o       = mem_q[rd_ptr_q];

    assign push = in_valid_i && in_ready_o;
    assign pop  = out_valid_o && out_ready_i;

    // Pointers wrap naturally at the power-of-two depth
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;
            end
            if (pop) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
            // Simultaneous push and pop leave the count alone
            if (push && !pop) begin
                count_q <= count_q + 1'b1;
            end else if (pop && !push) begin
                count_q <= count_q - 1'b1;
            end
        end
    end

    // Entry storage
    always_ff @(posedge clk_i) begin
        if (push) begin
            mem_q[wr_ptr_q] <= in_i;
        end
    end

endmodule

/* design/result_collector.sv */
/*
 * Purely combinational. Register write and scoreboard release happen only
 * on the writeback handshake, so a stalled port keeps the register pending.
 */
`timescale 1ns/1ps

module result_collector import bgpu_pkg::*; (
    // From the result buffer
    input  logic       res_valid_i,
    output logic       res_ready_o,
    input  iu_result_t res_i,

    // Writeback port
    output logic       wb_valid_o,
    input  logic       wb_ready_i,
    output wb_t        wb_o,

    // Register file write port
    output logic       wr_en_o,
    output wid_t       wr_wid_o,
    output reg_idx_t   wr_idx_o,
    output warp_data_t wr_data_o,

    // Scoreboard release
    output logic       clr_valid_o,
    output wid_t       clr_wid_o,
    output reg_idx_t   clr_dst_o
);

    wid_t wid;
    logic fire;

    // Warp ID lives in the low bits of the iid
    assign wid  = res_i.iid[WID_WIDTH-1:0];
    assign fire = res_valid_i && wb_ready_i;

    // Buffer head straight to the port
    assign wb_valid_o  = res_valid_i;
    assign res_ready_o = wb_ready_i;
    assign wb_o.wid    = wid;
    assign wb_o.dst    = res_i.dst;
    assign wb_o.data   = res_i.data;

    // Commit on handshake
    assign wr_en_o   = fire;
    assign wr_wid_o  = wid;
    assign wr_idx_o  = res_i.dst;
    assign wr_data_o = res_i.data;

    // Release the destination in the same cycle
    assign clr_valid_o = fire;
    assign clr_wid_o   = wid;
    assign clr_dst_o   = res_i.dst;

endmodule

/* design/bgpu_int_cluster.sv */
/*
 * Integer execution path of one compute unit. At least 3 cycles from issue
 * to writeback, results leave in issue order.
 */
`timescale 1ns/1ps

module bgpu_int_cluster import bgpu_pkg::*; (
    input  logic   clk_i,
    input  logic   rst_i,

    // Issue port
    input  logic   issue_valid_i,
    output logic   issue_ready_o,
    input  issue_t issue_i,

    // Writeback port
    output logic   wb_valid_o,
    input  logic   wb_ready_i,
    output wb_t    wb_o
);

    // ############################
    // Internal wiring
    // ############################

    // Register file read side
    logic       rd_en;
    wid_t       rd_wid;
    reg_idx_t   rd_idx0;
    reg_idx_t   rd_idx1;
    warp_data_t rd_data0;
    warp_data_t rd_data1;

    // Register file write side
    logic       wr_en;
    wid_t       wr_wid;
    reg_idx_t   wr_idx;
    warp_data_t wr_data;

    // Scoreboard release
    logic       clr_valid;
    wid_t       clr_wid;
    reg_idx_t   clr_dst;

    // Collector to unit
    logic       req_valid;
    logic       req_ready;
    iu_req_t    req;

    // Unit to buffer
    logic       res_valid;
    logic       res_ready;
    iu_result_t res;

    // Buffer to result collector
    logic       head_valid;
    logic       head_ready;
    iu_result_t head;

    // ############################
    // Instances
    // ############################

    operand_collector u_opc (
        .clk_i         (clk_i),
        .rst_i         (rst_i),
        .issue_valid_i (issue_valid_i),
        .issue_ready_o (issue_ready_o),
        .issue_i       (issue_i),
        .rd_en_o       (rd_en),
        .rd_wid_o      (rd_wid),
        .rd_idx0_o     (rd_idx0),
        .rd_idx1_o     (rd_idx1),
        .rd_data0_i    (rd_data0),
        .rd_data1_i    (rd_data1),
        .clr_valid_i   (clr_valid),
        .clr_wid_i     (clr_wid),
        .clr_dst_i     (clr_dst),
        .req_valid_o   (req_valid),
        .req_ready_i   (req_ready),
        .req_o         (req)
    );

    warp_register_file u_rf (
        .clk_i      (clk_i),
        .rst_i      (rst_i),
        .rd_en_i    (rd_en),
        .rd_wid_i   (rd_wid),
        .rd_idx0_i  (rd_idx0),
        .rd_idx1_i  (rd_idx1),
        .rd_data0_o (rd_data0),
        .rd_data1_o (rd_data1),
        .wr_en_i    (wr_en),
        .wr_wid_i   (wr_wid),
        .wr_idx_i   (wr_idx),
        .wr_data_i  (wr_data)
    );

    integer_unit u_iu (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .req_valid_i (req_valid),
        .req_ready_o (req_ready),
        .req_i       (req),
        .res_valid_o (res_valid),
        .res_ready_i (res_ready),
        .res_o       (res)
    );

    result_buffer u_rb (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .in_valid_i  (res_valid),
        .in_ready_o  (res_ready),
        .in_i        (res),
        .out_valid_o (head_valid),
        .out_ready_i (head_ready),
        .out_o       (head)
    );

    result_collector u_rc (
        .res_valid_i (head_valid),
        .res_ready_o (head_ready),
        .res_i       (head),
        .wb_valid_o  (wb_valid_o),
        .wb_ready_i  (wb_ready_i),
        .wb_o        (wb_o),
        .wr_en_o     (wr_en),
        .wr_wid_o    (wr_wid),
        .wr_idx_o    (wr_idx),
        .wr_data_o   (wr_data),
        .clr_valid_o (clr_valid),
        .clr_wid_o   (clr_wid),
        .clr_dst_o   (clr_dst)
    );

endmodule

/* bench/tb_model.svh */
/*
 * Reference model, included inside the testbench module after bgpu_pkg import.
 * The register mirror must be updated in issue order, one call per instruction.
 */
`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

// Register file mirror, one warp-wide word per warp and index
warp_data_t mirror [NUM_WARPS][NUM_REGS];

// Plain 32-bit xorshift step
function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
endfunction

function automatic void clear_mirror();
    for (int w = 0; w < NUM_WARPS; w++) begin
        for (int r = 0; r < NUM_REGS; r++) begin
            mirror[w][r] = '0;
        end
    end
endfunction

// One thread's value, operand 1 op operand 0
function automatic reg_data_t thread_value(input iu_subtype_e op, input int thread,
                                           input wid_t wid, input reg_data_t op0,
                                           input reg_data_t op1);
    case (op)
        IU_TID:           return reg_data_t'(thread);
        IU_WID:           return reg_data_t'(wid);
        IU_ADD, IU_ADDI:  return op1 + op0;
        IU_SUB, IU_SUBI:  return op1 - op0;
        IU_LDI:           return op0;
        IU_OR:            return op1 | op0;
        IU_AND:           return op1 & op0;
        IU_XOR:           return op1 ^ op0;
        // Large shift amounts push everything out
        IU_SLL, IU_SLLI:  return op1 << op0;
        default:          return '1;
    endcase
endfunction

// Expected writeback of one instruction, then commit to the mirror
function automatic wb_t predict(input issue_t ins);
    wb_t       w;
    reg_data_t op0;
    reg_data_t op1;
    logic      imm_op;
    imm_op = ins.subtype inside {IU_ADDI, IU_SUBI, IU_SLLI, IU_LDI};
    w.wid  = ins.wid;
    w.dst  = ins.dst;
    w.data = '0;
    for (int t = 0; t < WARP_WIDTH; t++) begin
        op0 = imm_op ? ins.imm : mirror[ins.wid][ins.src0][t*REG_WIDTH +: REG_WIDTH];
        op1 = (ins.subtype == IU_LDI) ? '0 : mirror[ins.wid][ins.src1][t*REG_WIDTH +: REG_WIDTH];
        w.data[t*REG_WIDTH +: REG_WIDTH] = thread_value(ins.subtype, t, ins.wid, op0, op1);
    end
    mirror[ins.wid][ins.dst] = w.data;
    return w;
endfunction

`endif

/* bench/tb_bgpu_int_cluster.sv */
/*
 * Drives the integer cluster with defined subtypes only. Register 0 is never written.
 * A watchdog bounds the run at 50 cycles per instruction.
 */
`timescale 1ns/1ps

module tb_bgpu_int_cluster import bgpu_pkg::*; ();

    localparam int          CLK_PERIOD      = 20;
    localparam int          RESET_CYCLES    = 8;
    localparam int          NUM_INSTR       = 140;
    localparam int          WATCHDOG_CYCLES = NUM_INSTR * 50 + RESET_CYCLES;
    localparam logic [31:0] SEED            = 32'h750f;

    localparam iu_subtype_e REG_OPS [6] = '{IU_ADD, IU_SUB, IU_OR, IU_AND, IU_XOR, IU_SLL};
    localparam iu_subtype_e CHAIN_OPS [6] = '{IU_ADD, IU_ADDI, IU_XOR, IU_SUBI, IU_SLLI, IU_OR};
    localparam iu_subtype_e ALL_OPS [12] = '{IU_TID, IU_WID, IU_ADD, IU_ADDI, IU_SUB, IU_SUBI,
                                             IU_LDI, IU_OR, IU_AND, IU_XOR, IU_SLL, IU_SLLI};

    logic   clk_i;
    logic   rst_i;
    logic   issue_valid_i;
    logic   issue_ready_o;
    issue_t issue_i;
    logic   wb_valid_o;
    logic   wb_ready_i;
    wb_t    wb_o;

    // Expected writebacks in issue order
    wb_t         exp_q [$];
    int          mon_errors;
    int          mon_checks;
    int          stim_errors;
    int          stim_checks;
    int          test_count;
    int          fail_tests;
    logic [31:0] rand_state;
    logic [31:0] ready_state;
    logic        backpressure;

    `include "tb_model.svh"

    bgpu_int_cluster i_dut (
        .clk_i         (clk_i),
        .rst_i         (rst_i),
        .issue_valid_i (issue_valid_i),
        .issue_ready_o (issue_ready_o),
        .issue_i       (issue_i),
        .wb_valid_o    (wb_valid_o),
        .wb_ready_i    (wb_ready_i),
        .wb_o          (wb_o)
    );

    // ############################
    // Clock, watchdog, ready
    // ############################

    initial begin
        clk_i = 1'b0;
        forever #(CLK_PERIOD/2) clk_i = ~clk_i;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk_i);
        $display("timeout: results did not drain within %0d cycles", WATCHDOG_CYCLES);
        $display("Simulation finished: FAIL");
        $finish;
    end

    // Writeback ready is random only in the back-pressure test
    initial begin
        wb_ready_i  = 1'b1;
        ready_state = xorshift32(SEED);
        forever begin
            @(negedge clk_i);
            if (backpressure) begin
                ready_state = xorshift32(ready_state);
                wb_ready_i  = ready_state[7];
            end else begin
                wb_ready_i = 1'b1;
            end
        end
    end

    // ############################
    // Writeback checking
    // ############################

    always @(posedge clk_i) begin
        if (!rst_i && wb_valid_o && wb_ready_i) begin
            mon_checks++;
            assert (exp_q.size() != 0) else begin
                mon_errors++;
                $display("writeback at %0t with no instruction outstanding", $time);
            end
            if (exp_q.size() != 0) begin
                assert (wb_o == exp_q[0]) else begin
                    mon_errors++;
                    $display("error at %0t: wb_o expected %h got %h", $time, exp_q[0], wb_o);
                end
                void'(exp_q.pop_front());
            end
        end
    end

    // ############################
    // Stimulus helpers
    // ############################

    function automatic logic [31:0] rand_word();
        rand_state = xorshift32(rand_state);
        return rand_state;
    endfunction

    function automatic int total_errors();
        return mon_errors + stim_errors;
    endfunction

    // Starts on a falling edge and returns on the falling edge after acceptance
    task automatic send_instr(input int wid, input iu_subtype_e op, input int dst,
                              input int src0, input int src1, input reg_data_t imm);
        issue_t ins;
        ins.wid     = wid_t'(wid);
        ins.subtype = op;
        ins.dst     = reg_idx_t'(dst);
        ins.src0    = reg_idx_t'(src0);
        ins.src1    = reg_idx_t'(src1);
        ins.imm     = imm;
        exp_q.push_back(predict(ins));
        issue_i       = ins;
        issue_valid_i = 1'b1;
        @(posedge clk_i);
        while (!issue_ready_o) begin
            @(posedge clk_i);
        end
        @(negedge clk_i);
        issue_valid_i = 1'b0;
    endtask

    task automatic drain_results();
        while (exp_q.size() != 0) begin
            @(negedge clk_i);
        end
    endtask

    task automatic end_test(input string name, input int errors_before);
        test_count++;
        if (total_errors() == errors_before) begin
            $display("test %s: pass", name);
        end else begin
            fail_tests++;
            $display("test %s: fail, %0d errors", name, total_errors() - errors_before);
        end
    endtask

    // ############################
    // Test sequence
    // ############################

    initial begin
        int          errs;
        logic [31:0] r;
        iu_subtype_e op;
        rst_i         = 1'b1;
        issue_valid_i = 1'b0;
        issue_i       = '0;
        rand_state    = SEED;
        backpressure  = 1'b0;
        mon_errors    = 0;
        mon_checks    = 0;
        stim_errors   = 0;
        stim_checks   = 0;
        test_count    = 0;
        fail_tests    = 0;
        clear_mirror();
        repeat (RESET_CYCLES) @(posedge clk_i);
        @(negedge clk_i);
        rst_i = 1'b0;
        @(negedge clk_i);

        // Idle state before any issue
        errs = total_errors();
        stim_checks++;
        assert (issue_ready_o === 1'b1 && wb_valid_o === 1'b0) else begin
            stim_errors++;
            $display("error at %0t: issue_ready_o/wb_valid_o expected 1/0 got %b/%b",
                     $time, issue_ready_o, wb_valid_o);
        end
        end_test("reset", errs);

        // Thread and warp IDs
        errs = total_errors();
        for (int w = 0; w < NUM_WARPS; w++) begin
            send_instr(w, IU_TID, 1, 0, 0, '0);
            send_instr(w, IU_WID, 2, 0, 0, '0);
        end
        drain_results();
        end_test("tid_wid", errs);

        // Immediates where ADDI and SUBI cross zero
        errs = total_errors();
        for (int w = 0; w < NUM_WARPS; w++) begin
            send_instr(w, IU_LDI, 3, 0, 0, rand_word());
            send_instr(w, IU_LDI, 4, 0, 0, 32'hffff_fff0);
            send_instr(w, IU_ADDI, 5, 0, 4, 32'h0000_0020);
            send_instr(w, IU_SUBI, 6, 0, 3, rand_word());
            send_instr(w, IU_SUBI, 7, 0, 0, 32'h0000_0001);
            send_instr(w, IU_SLLI, 8, 0, 3, rand_word() & 32'h1f);
        end
        drain_results();
        end_test("immediates", errs);

        // Random register contents and then register ops across warps
        errs = total_errors();
        for (int w = 0; w < NUM_WARPS; w++) begin
            for (int k = 9; k <= 12; k++) begin
                send_instr(w, IU_LDI, k, 0, 0, rand_word());
            end
        end
        for (int n = 0; n < 24; n++) begin
            r  = rand_word();
            op = REG_OPS[int'(r % 32'd6)];
            // SLL shifts by the thread index held in r1
            send_instr(int'(r[9:8]), op, 9 + int'(r[14:12]) % 7,
                       (op == IU_SLL) ? 1 : 1 + int'(r[23:20]) % 12,
                       1 + int'(r[19:16]) % 12, '0);
        end
        drain_results();
        end_test("register_ops", errs);

        // Chains through r14
        errs = total_errors();
        for (int w = 0; w < NUM_WARPS; w++) begin
            send_instr(w, IU_LDI, 14, 0, 0, rand_word());
            for (int s = 0; s < 6; s++) begin
                send_instr(w, CHAIN_OPS[s], 14, 1, 14, rand_word() & 32'h7);
            end
        end
        drain_results();
        end_test("dependence", errs);

        // Random writeback stalls
        errs = total_errors();
        // Mode switches on the rising edge so the ready process sees it at the next fall
        @(posedge clk_i);
        backpressure = 1'b1;
        @(negedge clk_i);
        for (int n = 0; n < 40; n++) begin
            r  = rand_word();
            op = ALL_OPS[int'(r % 32'd12)];
            send_instr(int'(r[9:8]), op, 1 + int'(r[13:10]) % 15, 1 + int'(r[17:14]) % 15,
                       1 + int'(r[21:18]) % 15,
                       (op == IU_SLLI) ? (rand_word() & 32'h1f) : rand_word());
        end
        drain_results();
        @(posedge clk_i);
        backpressure = 1'b0;
        // Room for a stray duplicate to show up
        repeat (10) @(negedge clk_i);
        stim_checks++;
        assert (exp_q.size() == 0 && !wb_valid_o) else begin
            stim_errors++;
            $display("results left over after the back-pressure run");
        end
        end_test("backpressure", errs);

        $display("tests: %0d, failed: %0d, checks: %0d, errors: %0d", test_count, fail_tests,
                 mon_checks + stim_checks, total_errors());
        if (fail_tests == 0 && total_errors() == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

/* verilog.f */
+incdir+bench
design/bgpu_pkg.sv
design/warp_register_file.sv
design/operand_collector.sv
design/integer_unit.sv
design/result_buffer.sv
design/result_collector.sv
design/bgpu_int_cluster.sv
bench/tb_bgpu_int_cluster.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the integer cluster testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
    -f verilog.f --top-module tb_bgpu_int_cluster -Mdir obj_dir

status=0
./obj_dir/Vtb_bgpu_int_cluster > sim.log 2>&1 || status=$?
cat sim.log

if [ "$status" -ne 0 ] || grep -q "Simulation finished: FAIL" sim.log; then
    echo "simulation failed"
    exit 1
fi
echo "simulation passed"
